// ==== pcie_tx_pkg.sv ====
//**********************************************************
// shared constants, payload and beat types for the PCIe tx
// bridge; referenced by scoped name from RTL and testbench
//**********************************************************
`default_nettype none

package pcie_tx_pkg;

   localparam logic [7:0] FMT_CPLD  = 8'h4A;  // completion with data
   localparam logic [7:0] FMT_MRD32 = 8'h00;
   localparam logic [7:0] FMT_MRD64 = 8'h20;
   localparam logic [7:0] FMT_MWR32 = 8'h40;
   localparam logic [7:0] FMT_MWR64 = 8'h60;

   localparam logic [9:0] RD_LEN_DW = 10'd128;  // every read asks for 512 bytes
   localparam logic [7:0] BYTE_EN   = 8'hFF;    // last/first byte enables

   typedef struct packed {
      logic [31:0] dw2;   // third completion header dword
      logic [31:0] data;
   } cpl_t;

   typedef struct packed {
      logic [63:0] addr;
      logic [7:0]  tag;
   } rd_req_t;

   typedef struct packed {
      logic [63:0] addr;  // sampled on first word only
      logic [63:0] data;
   } wr_word_t;

   typedef struct packed {
      logic [63:0] data;
      logic        last;
      logic        one_dw;  // only low dword valid, last beat only
   } tlp_beat_t;

   // PCIe payload is big endian per dword
   function automatic logic [31:0] byte_swap32(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

`default_nettype wire

// ==== req_if.sv ====
//**********************************************************
// valid/ready request stream with a last marker; payload
// type set per instance
//**********************************************************
`default_nettype none

interface req_if #(
   parameter type T_PAYLOAD = logic
) ();

   logic     valid;
   logic     ready;
   logic     last;     // final transfer of a burst
   T_PAYLOAD payload;

   // producer side
   modport src (
      output valid,
      output last,
      output payload,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  last,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

// ==== fwft_fifo.sv ====
//**********************************************************
// single clock first-word-fall-through FIFO; head is valid
// while o_valid is high, o_room flags space for one packet
//**********************************************************
`default_nettype none

module fwft_fifo #(
   parameter type T_DATA       = logic,
   parameter int  P_FIFO_DEPTH = 32,
   parameter int  P_WR_BURST   = 16
) (
   input  wire logic  clock,
   input  wire logic  reset,
   input  wire T_DATA i_data,
   input  wire logic  i_write,
   output logic       o_room,
   output T_DATA      o_data,
   output logic       o_valid,
   input  wire logic  i_read
);

   localparam int AW = $clog2(P_FIFO_DEPTH);
   localparam int CW = $clog2(P_FIFO_DEPTH + 1);

   T_DATA         mem [P_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_write;
   logic          do_read;

   assign do_read  = i_read && o_valid;
   assign do_write = i_write && (count < CW'(P_FIFO_DEPTH));

   assign o_data  = mem[rd_ptr];
   assign o_valid = (count != '0);
   // largest packet plus the beat still in the formatter's output register
   assign o_room  = (CW'(P_FIFO_DEPTH) - count) >= CW'(P_WR_BURST + 3);

   always_ff @(posedge clock)
   begin
      if (do_write)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= (wr_ptr == AW'(P_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= (rd_ptr == AW'(P_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== req_arbiter.sv ====
//**********************************************************
// round-robin arbiter over N_SRC request streams; a grant
// is held until a transfer with last, so bursts stay whole
//**********************************************************
`default_nettype none

module req_arbiter #(
   parameter type T_PAYLOAD = logic,
   parameter int  N_SRC     = 2
) (
   input wire logic clock,
   input wire logic reset,
   req_if.snk       i_src [N_SRC],
   req_if.src       o_req
);

   localparam int W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

   logic [W-1:0]     grant;
   logic [W-1:0]     next_grant;
   logic             locked;  // inside a burst
   logic             xfer;
   logic [N_SRC-1:0] src_valid;
   logic [N_SRC-1:0] src_last;
   T_PAYLOAD         src_payload [N_SRC];

   // flatten the interface array so it can be indexed by grant
   generate
      for (genvar g = 0; g < N_SRC; g++)
      begin : g_src
         assign src_valid[g]   = i_src[g].valid;
         assign src_last[g]    = i_src[g].last;
         assign src_payload[g] = i_src[g].payload;
         assign i_src[g].ready = o_req.ready && (grant == W'(g));
      end
   endgenerate

   assign o_req.valid   = src_valid[grant];
   assign o_req.last    = src_last[grant];
   assign o_req.payload = src_payload[grant];

   assign xfer = o_req.valid && o_req.ready;

   // first valid source after the current one, wrapping back to itself
   always_comb
   begin
      int idx;
      next_grant = W'((int'(grant) + 1) % N_SRC);  // nobody waiting
      for (int i = N_SRC; i >= 1; i--)
      begin
         idx = (int'(grant) + i) % N_SRC;
         if (src_valid[idx])
            next_grant = W'(idx);  // smallest offset wins
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         grant  <= '0;
         locked <= 1'b0;
      end
      else if (xfer)
      begin
         locked <= !o_req.last;
         if (o_req.last)
            grant <= next_grant;
      end
      else if (!locked && !o_req.valid)
         grant <= next_grant;  // hop to a waiting source between bursts
   end

endmodule

`default_nettype wire

// ==== tlp_tx_formatter.sv ====
//**********************************************************
// builds completion, memory read and memory write TLPs as
// 64-bit beats; a packet only starts while the FIFO has room
//**********************************************************
`default_nettype none

module tlp_tx_formatter #(
   parameter int P_WR_BURST = 16
) (
   input  wire logic        clock,
   input  wire logic        reset,
   input  wire logic [15:0] i_pci_id,
   req_if.snk               i_cpl,
   req_if.snk               i_rd,
   req_if.snk               i_wr,
   input  wire logic        i_fifo_room,
   output pcie_tx_pkg::tlp_beat_t o_beat,
   output logic             o_beat_write
);

   localparam int         CW        = $clog2(P_WR_BURST + 1);
   localparam logic [9:0] WR_LEN_DW = 10'(2 * P_WR_BURST);

   typedef enum logic [3:0] {
      S_IDLE, S_CPL0, S_CPL1, S_RD0, S_RD1,
      S_WR_HDR, S_WR_ADDR, S_WR_DATA, S_WR_TAIL
   } state_t;

   state_t                 state;
   state_t                 next_state;
   logic [CW-1:0]          word_cnt;
   logic                   cpl_xfer;
   logic                   rd_xfer;
   logic                   wr_xfer;
   logic                   last_word;
   logic                   rd_in64;
   logic                   wr_in64;
   logic                   addr_is64;
   logic                   beat_en;
   pcie_tx_pkg::tlp_beat_t beat_d;
   pcie_tx_pkg::cpl_t      cpl_q;
   logic [63:0]            addr_q;  // read or write address
   logic [31:0]            held;    // odd dword carried to the next beat

   function automatic logic [63:0] make_hdr(input logic [7:0] fmt, input logic [9:0] len,
                                            input logic [31:0] dw1);
      return {dw1, fmt, 14'd0, len};  // DW1 high, DW0 low
   endfunction

   assign i_cpl.ready = (state == S_CPL0);
   assign i_rd.ready  = (state == S_RD0);
   assign i_wr.ready  = (state == S_WR_DATA);

   assign cpl_xfer  = i_cpl.valid && i_cpl.ready;
   assign rd_xfer   = i_rd.valid && i_rd.ready;
   assign wr_xfer   = i_wr.valid && i_wr.ready;
   assign last_word = (word_cnt == CW'(P_WR_BURST - 1));
   assign rd_in64   = |i_rd.payload.addr[63:32];
   assign wr_in64   = |i_wr.payload.addr[63:32];
   assign addr_is64 = |addr_q[63:32];

   always_comb
   begin
      next_state = state;
      beat_en    = 1'b0;
      beat_d     = '0;
      case (state)
         S_IDLE:  // priority cpl, read, write
         begin
            if (i_fifo_room && i_cpl.valid)
               next_state = S_CPL0;
            else if (i_fifo_room && i_rd.valid)
               next_state = S_RD0;
            else if (i_fifo_room && i_wr.valid)
               next_state = S_WR_HDR;
         end
         S_CPL0:
         begin
            if (cpl_xfer)
            begin
               beat_en     = 1'b1;
               beat_d.data = make_hdr(pcie_tx_pkg::FMT_CPLD, 10'd1, {i_pci_id, 16'd4});
               next_state  = S_CPL1;
            end
         end
         S_CPL1:
         begin
            beat_en     = 1'b1;
            beat_d.data = {pcie_tx_pkg::byte_swap32(cpl_q.data), cpl_q.dw2};
            beat_d.last = 1'b1;
            next_state  = S_IDLE;
         end
         S_RD0:
         begin
            if (rd_xfer)
            begin
               beat_en     = 1'b1;
               beat_d.data = make_hdr(rd_in64 ? pcie_tx_pkg::FMT_MRD64 : pcie_tx_pkg::FMT_MRD32,
                                      pcie_tx_pkg::RD_LEN_DW,
                                      {i_pci_id, i_rd.payload.tag, pcie_tx_pkg::BYTE_EN});
               next_state  = S_RD1;
            end
         end
         S_RD1:
         begin
            beat_en       = 1'b1;
            beat_d.data   = addr_q;  // high dword is zero for a 32-bit address
            beat_d.last   = 1'b1;
            beat_d.one_dw = !addr_is64;
            next_state    = S_IDLE;
         end
         S_WR_HDR:  // addr held stable before the first word
         begin
            beat_en     = 1'b1;
            beat_d.data = make_hdr(wr_in64 ? pcie_tx_pkg::FMT_MWR64 : pcie_tx_pkg::FMT_MWR32,
                                   WR_LEN_DW, {i_pci_id, 8'd0, pcie_tx_pkg::BYTE_EN});
            next_state  = wr_in64 ? S_WR_ADDR : S_WR_DATA;
         end
         S_WR_ADDR:
         begin
            beat_en     = 1'b1;
            beat_d.data = addr_q;
            next_state  = S_WR_DATA;
         end
         S_WR_DATA:
         begin
            if (wr_xfer)
            begin
               beat_en = 1'b1;
               if (addr_is64)
                  beat_d.data = {pcie_tx_pkg::byte_swap32(i_wr.payload.data[63:32]),
                                 pcie_tx_pkg::byte_swap32(i_wr.payload.data[31:0])};
               else
                  beat_d.data = {pcie_tx_pkg::byte_swap32(i_wr.payload.data[31:0]), held};
               beat_d.last = last_word && addr_is64;
               if (last_word)
                  next_state = addr_is64 ? S_IDLE : S_WR_TAIL;
            end
         end
         S_WR_TAIL:  // leftover high dword of the final word
         begin
            beat_en       = 1'b1;
            beat_d.data   = {32'd0, held};
            beat_d.last   = 1'b1;
            beat_d.one_dw = 1'b1;
            next_state    = S_IDLE;
         end
         default: next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge clock)
   begin
      o_beat <= beat_d;
      if (cpl_xfer)
         cpl_q <= i_cpl.payload;
      if (rd_xfer)
         addr_q <= i_rd.payload.addr;
      else if (state == S_WR_HDR)
         addr_q <= i_wr.payload.addr;
      if (state == S_WR_HDR)
         held <= i_wr.payload.addr[31:0];  // 32-bit addr rides with first data dword
      else if (wr_xfer)
         held <= pcie_tx_pkg::byte_swap32(i_wr.payload.data[63:32]);
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state        <= S_IDLE;
         o_beat_write <= 1'b0;
         word_cnt     <= '0;
      end
      else
      begin
         state        <= next_state;
         o_beat_write <= beat_en;
         if (wr_xfer)
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== pcie_tx_top.sv ====
//**********************************************************
// PCIe tx bridge top; read and write sources are arbitrated,
// formatted into TLP beats and queued for the core's AXI port
//**********************************************************
`default_nettype none

module pcie_tx_top #(
   parameter int P_WR_BURST   = 16,
   parameter int P_FIFO_DEPTH = 32  // at least P_WR_BURST + 3
) (
   input  wire logic             clock,
   input  wire logic             reset,
   input  wire logic [15:0]      i_pci_id,
   // completion source
   input  wire logic             i_cpl_valid,
   input  wire logic [31:0]      i_cpl_dw2,
   input  wire logic [31:0]      i_cpl_data,
   output logic                  o_cpl_ready,
   // read sources
   input  wire logic [1:0]       i_rd_valid,
   input  wire logic [1:0][63:0] i_rd_addr,
   input  wire logic [1:0][7:0]  i_rd_tag,
   output logic [1:0]            o_rd_ready,
   // write sources
   input  wire logic [1:0]       i_wr_valid,
   input  wire logic [1:0]       i_wr_last,
   input  wire logic [1:0][63:0] i_wr_addr,
   input  wire logic [1:0][63:0] i_wr_data,
   output logic [1:0]            o_wr_ready,
   // AXI stream to the PCIe core
   input  wire logic             i_tx_ready,
   output logic                  o_tx_valid,
   output logic [63:0]           o_tx_data,
   output logic                  o_tx_last,
   output logic                  o_tx_1dw
);

   localparam int N_SRC = 2;

   req_if #(.T_PAYLOAD(pcie_tx_pkg::cpl_t))     cpl_if ();
   req_if #(.T_PAYLOAD(pcie_tx_pkg::rd_req_t))  rd_src_if [N_SRC] ();
   req_if #(.T_PAYLOAD(pcie_tx_pkg::wr_word_t)) wr_src_if [N_SRC] ();
   req_if #(.T_PAYLOAD(pcie_tx_pkg::rd_req_t))  rd_req_if ();
   req_if #(.T_PAYLOAD(pcie_tx_pkg::wr_word_t)) wr_req_if ();

   pcie_tx_pkg::tlp_beat_t beat;
   pcie_tx_pkg::tlp_beat_t head;
   logic                   beat_write;
   logic                   fifo_room;

   assign cpl_if.valid   = i_cpl_valid;
   assign cpl_if.last    = 1'b1;  // single transfer
   assign cpl_if.payload = '{dw2: i_cpl_dw2, data: i_cpl_data};
   assign o_cpl_ready    = cpl_if.ready;

   generate
      for (genvar g = 0; g < N_SRC; g++)
      begin : g_src
         assign rd_src_if[g].valid   = i_rd_valid[g];
         assign rd_src_if[g].last    = 1'b1;
         assign rd_src_if[g].payload = '{addr: i_rd_addr[g], tag: i_rd_tag[g]};
         assign o_rd_ready[g]        = rd_src_if[g].ready;

         assign wr_src_if[g].valid   = i_wr_valid[g];
         assign wr_src_if[g].last    = i_wr_last[g];
         assign wr_src_if[g].payload = '{addr: i_wr_addr[g], data: i_wr_data[g]};
         assign o_wr_ready[g]        = wr_src_if[g].ready;
      end
   endgenerate

   req_arbiter #(.T_PAYLOAD(pcie_tx_pkg::rd_req_t), .N_SRC(N_SRC)) rd_arbiter (
      .clock (clock),
      .reset (reset),
      .i_src (rd_src_if),
      .o_req (rd_req_if)
   );

   req_arbiter #(.T_PAYLOAD(pcie_tx_pkg::wr_word_t), .N_SRC(N_SRC)) wr_arbiter (
      .clock (clock),
      .reset (reset),
      .i_src (wr_src_if),
      .o_req (wr_req_if)
   );

   tlp_tx_formatter #(.P_WR_BURST(P_WR_BURST)) formatter (
      .clock        (clock),
      .reset        (reset),
      .i_pci_id     (i_pci_id),
      .i_cpl        (cpl_if),
      .i_rd         (rd_req_if),
      .i_wr         (wr_req_if),
      .i_fifo_room  (fifo_room),
      .o_beat       (beat),
      .o_beat_write (beat_write)
   );

   fwft_fifo #(
      .T_DATA       (pcie_tx_pkg::tlp_beat_t),
      .P_FIFO_DEPTH (P_FIFO_DEPTH),
      .P_WR_BURST   (P_WR_BURST)
   ) tx_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_data  (beat),
      .i_write (beat_write),
      .o_room  (fifo_room),
      .o_data  (head),
      .o_valid (o_tx_valid),
      .i_read  (o_tx_valid && i_tx_ready)  // beat accepted by the core
   );

   assign o_tx_data = head.data;
   assign o_tx_last = head.last;
   assign o_tx_1dw  = head.one_dw;

endmodule

`default_nettype wire

// ==== pcie_tx_asserts.sv ====
//**********************************************************
// protocol checks on the tx bridge stream ports; bound to
// every pcie_tx_top instance
//**********************************************************
`default_nettype none

module pcie_tx_asserts (
   input wire logic        clock,
   input wire logic        reset,
   input wire logic        i_tx_ready,
   input wire logic        o_tx_valid,
   input wire logic [63:0] o_tx_data,
   input wire logic        o_tx_last,
   input wire logic        o_tx_1dw,
   input wire logic        o_cpl_ready,
   input wire logic [1:0]  o_rd_ready,
   input wire logic [1:0]  o_wr_ready
);

   // nothing offered or accepted while in reset or just after
   quiet_after_reset: assert property (@(posedge clock)
      reset |=> !o_tx_valid && !o_cpl_ready && (o_rd_ready == 2'b00) && (o_wr_ready == 2'b00))
      else $error("stream ports active during or right after reset");

   // stalled head beat must hold
   stable_when_stalled: assert property (@(posedge clock) disable iff (reset)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last)
                                    && $stable(o_tx_1dw))
      else $error("head beat changed while the core stalled");

   one_dw_on_last: assert property (@(posedge clock) disable iff (reset)
      o_tx_valid && o_tx_1dw |-> o_tx_last)
      else $error("single dword flag on a beat that is not last");

endmodule

bind pcie_tx_top pcie_tx_asserts u_asserts (
   .clock       (clock),
   .reset       (reset),
   .i_tx_ready  (i_tx_ready),
   .o_tx_valid  (o_tx_valid),
   .o_tx_data   (o_tx_data),
   .o_tx_last   (o_tx_last),
   .o_tx_1dw    (o_tx_1dw),
   .o_cpl_ready (o_cpl_ready),
   .o_rd_ready  (o_rd_ready),
   .o_wr_ready  (o_wr_ready)
);

`default_nettype wire

// ==== tb_pcie_tx.sv ====
//**********************************************************
// testbench for the PCIe tx bridge; expected beats are built
// from accepted requests and checked against the core port
//**********************************************************
`default_nettype none

module tb_pcie_tx;

   localparam int WR_BURST = 4;
   localparam int MAX_CYCLES = 3000;

   logic             clock;
   logic             reset;
   logic [15:0]      i_pci_id;
   logic             i_cpl_valid;
   logic [31:0]      i_cpl_dw2;
   logic [31:0]      i_cpl_data;
   logic             o_cpl_ready;
   logic [1:0]       i_rd_valid;
   logic [1:0][63:0] i_rd_addr;
   logic [1:0][7:0]  i_rd_tag;
   logic [1:0]       o_rd_ready;
   logic [1:0]       i_wr_valid;
   logic [1:0]       i_wr_last;
   logic [1:0][63:0] i_wr_addr;
   logic [1:0][63:0] i_wr_data;
   logic [1:0]       o_wr_ready;
   logic             i_tx_ready;
   logic             o_tx_valid;
   logic [63:0]      o_tx_data;
   logic             o_tx_last;
   logic             o_tx_1dw;

   pcie_tx_pkg::tlp_beat_t exp_q [$];
   byte                    kind_log [$];   // C, R or W per accepted request
   int                     rd_src_log [$];
   logic [63:0]            wr_addr_q [2];
   logic [63:0]            wr_data_q [2][WR_BURST];
   int                     wr_words;
   int                     wr_owner;
   int                     cycles;
   int                     seed;
   logic                   random_ready;
   string                  test_name;

   pcie_tx_top #(.P_WR_BURST(WR_BURST), .P_FIFO_DEPTH(8)) uut (.*);

   initial
   begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   always @(posedge clock)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
         stop_with_error("timeout: the tests did not finish within the cycle limit");
   end

   // core back-pressure
   initial
   begin
      logic [31:0] rnd;
      i_tx_ready = 1'b0;
      forever
      begin
         @(posedge clock);
         #10;
         if (random_ready)
         begin
            rnd = $random(seed);
            i_tx_ready = rnd[0];
         end
         else
            i_tx_ready = 1'b1;
      end
   end

   function automatic logic [63:0] header_beat(input logic [7:0] fmt, input logic [9:0] len,
                                               input logic [31:0] dw1);
      return {dw1, fmt, 14'd0, len};
   endfunction

   task automatic push_beat(input logic [63:0] data, input logic last, input logic one_dw);
      pcie_tx_pkg::tlp_beat_t b;
      b.data   = data;
      b.last   = last;
      b.one_dw = one_dw;
      exp_q.push_back(b);
   endtask

   task automatic expect_cpl(input logic [31:0] dw2, input logic [31:0] data);
      push_beat(header_beat(pcie_tx_pkg::FMT_CPLD, 10'd1, {i_pci_id, 16'd4}), 1'b0, 1'b0);
      push_beat({pcie_tx_pkg::byte_swap32(data), dw2}, 1'b1, 1'b0);
   endtask

   task automatic expect_read(input logic [63:0] addr, input logic [7:0] tag);
      logic is64;
      is64 = (addr[63:32] != 32'd0);
      push_beat(header_beat(is64 ? pcie_tx_pkg::FMT_MRD64 : pcie_tx_pkg::FMT_MRD32,
                            pcie_tx_pkg::RD_LEN_DW, {i_pci_id, tag, pcie_tx_pkg::BYTE_EN}),
                1'b0, 1'b0);
      push_beat(addr, 1'b1, !is64);
   endtask

   // address then payload dwords packed two per beat with the low half first
   task automatic expect_write(input int k);
      logic [31:0] dws [$];
      logic        is64;
      int          i;
      is64 = (wr_addr_q[k][63:32] != 32'd0);
      push_beat(header_beat(is64 ? pcie_tx_pkg::FMT_MWR64 : pcie_tx_pkg::FMT_MWR32,
                            10'(2 * WR_BURST), {i_pci_id, 8'd0, pcie_tx_pkg::BYTE_EN}),
                1'b0, 1'b0);
      dws.push_back(wr_addr_q[k][31:0]);
      if (is64)
         dws.push_back(wr_addr_q[k][63:32]);
      for (i = 0; i < WR_BURST; i++)
      begin
         dws.push_back(pcie_tx_pkg::byte_swap32(wr_data_q[k][i][31:0]));
         dws.push_back(pcie_tx_pkg::byte_swap32(wr_data_q[k][i][63:32]));
      end
      for (i = 0; i < dws.size(); i += 2)
      begin
         if (i + 1 < dws.size())
            push_beat({dws[i+1], dws[i]}, i + 2 >= dws.size(), 1'b0);
         else
            push_beat({32'd0, dws[i]}, 1'b1, 1'b1);  // odd dword left over
      end
   endtask

   // scoreboard sampled mid-cycle where everything has settled
   always @(negedge clock)
   begin : monitor
      pcie_tx_pkg::tlp_beat_t exp_b;
      pcie_tx_pkg::tlp_beat_t act_b;
      if (!reset)
      begin
         if (o_cpl_ready && i_cpl_valid)
         begin
            expect_cpl(i_cpl_dw2, i_cpl_data);
            kind_log.push_back("C");
         end
         for (int k = 0; k < 2; k++)
         begin
            if (o_rd_ready[k] && i_rd_valid[k])
            begin
               expect_read(i_rd_addr[k], i_rd_tag[k]);
               rd_src_log.push_back(k);
               kind_log.push_back("R");
            end
            if (o_wr_ready[k] && i_wr_valid[k])
            begin
               if (wr_words == 0)
               begin
                  wr_owner = k;
                  expect_write(k);
                  kind_log.push_back("W");
               end
               assert (k == wr_owner)
               else stop_with_error("write bursts of two sources were interleaved");
               wr_words = i_wr_last[k] ? 0 : wr_words + 1;
            end
         end
         if (o_tx_valid && i_tx_ready)
         begin
            assert (exp_q.size() > 0)
            else stop_with_error("a beat left the bridge while none was expected");
            exp_b       = exp_q.pop_front();
            act_b.data  = o_tx_data;
            act_b.last  = o_tx_last;
            act_b.one_dw = o_tx_1dw;
            if (exp_b.one_dw)
               act_b.data[63:32] = 32'd0;  // upper half unused
            assert (act_b == exp_b)
            else stop_with_error($sformatf("Fail %s: expected %h actual %h",
                                           test_name, exp_b, act_b));
         end
      end
   end

   task automatic send_cpl(input logic [31:0] dw2, input logic [31:0] data);
      i_cpl_valid = 1'b1;
      i_cpl_dw2   = dw2;
      i_cpl_data  = data;
      do @(negedge clock); while (!o_cpl_ready);
      @(posedge clock);
      #10 i_cpl_valid = 1'b0;
   endtask

   // n requests with valid held high across them
   task automatic send_reads(input int k, input logic [63:0] base, input int n);
      for (int j = 0; j < n; j++)
      begin
         i_rd_valid[k] = 1'b1;
         i_rd_addr[k]  = base + 64'(j) * 64'h1000;
         i_rd_tag[k]   = 8'(k * 16 + j + 1);
         do @(negedge clock); while (!o_rd_ready[k]);
         @(posedge clock);
         #10;
      end
      i_rd_valid[k] = 1'b0;
   endtask

   task automatic send_burst(input int k, input logic [63:0] addr, input logic [31:0] base);
      for (int i = 0; i < WR_BURST; i++)
         wr_data_q[k][i] = {base + 32'(2 * i + 1), base + 32'(2 * i)};
      wr_addr_q[k] = addr;
      for (int i = 0; i < WR_BURST; i++)
      begin
         i_wr_valid[k] = 1'b1;
         i_wr_last[k]  = (i == WR_BURST - 1);
         i_wr_addr[k]  = addr;
         i_wr_data[k]  = wr_data_q[k][i];
         do @(negedge clock); while (!o_wr_ready[k]);
         @(posedge clock);
         #10;
      end
      i_wr_valid[k] = 1'b0;
      i_wr_last[k]  = 1'b0;
   endtask

   task automatic wait_drained();
      do @(negedge clock); while (exp_q.size() != 0 || o_tx_valid);
      repeat (2) @(posedge clock);
      #10;
   endtask

   initial
   begin
      seed = 32'h7373b147;
      cycles = 0;
      random_ready = 1'b0;
      wr_words = 0;
      wr_owner = 0;
      test_name = "reset";
      reset = 1'b1;
      i_pci_id = 16'h0A10;
      i_cpl_valid = 1'b0;
      i_cpl_dw2 = '0;
      i_cpl_data = '0;
      i_rd_valid = '0;
      i_rd_addr = '0;
      i_rd_tag = '0;
      i_wr_valid = '0;
      i_wr_last = '0;
      i_wr_addr = '0;
      i_wr_data = '0;
      repeat (4) @(posedge clock);
      #10 reset = 1'b0;

      test_name = "completion";
      send_cpl(32'h0A10_0C00, 32'h1122_3344);
      wait_drained();

      test_name = "read";
      send_reads(0, 64'h0000_0000_8000_0040, 1);
      send_reads(1, 64'h0000_0012_3456_7800, 1);
      wait_drained();

      test_name = "write";
      send_burst(0, 64'h0000_0000_9000_0000, 32'hA1B2_C300);
      send_burst(1, 64'h0000_0034_0000_1000, 32'h5566_7700);
      wait_drained();

      test_name = "arbitration";
      rd_src_log.delete();
      fork
         send_reads(0, 64'h0000_0000_4000_0000, 2);
         send_reads(1, 64'h0000_0001_4000_0000, 2);
      join
      wait_drained();
      for (int i = 1; i < rd_src_log.size(); i++)
         assert (rd_src_log[i] != rd_src_log[i-1])
         else stop_with_error("read sources were not served alternately");
      fork
         send_burst(0, 64'h0000_0000_2000_0000, 32'h0102_0300);
         send_burst(1, 64'h0000_0056_0000_0000, 32'hF0E0_D000);
      join
      wait_drained();
      kind_log.delete();
      fork
         send_cpl(32'h0A10_0D04, 32'hCAFE_0001);
         send_reads(0, 64'h0000_0000_6000_0000, 1);
         send_burst(1, 64'h0000_0000_7000_0000, 32'h3132_3300);
      join
      wait_drained();
      assert (kind_log.size() > 0 && kind_log[0] == "C")
      else stop_with_error("completion was not served before read and write");

      test_name = "backpressure";
      random_ready = 1'b1;
      fork
         begin
            send_cpl(32'h0A10_0E00, 32'hDEAD_BEEF);
            send_cpl(32'h0A10_0E04, 32'h0BAD_F00D);
         end
         send_reads(0, 64'h0000_0000_0100_0000, 3);
         send_reads(1, 64'h0000_00AB_0200_0000, 2);
         begin
            send_burst(0, 64'h0000_0000_0300_0000, 32'h4142_4300);
            send_burst(0, 64'h0000_0078_0400_0000, 32'h5152_5300);
         end
         send_burst(1, 64'h0000_0000_0500_0000, 32'h6162_6300);
      join
      wait_drained();
      random_ready = 1'b0;

      if (exp_q.size() == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
         stop_with_error("expected beats never arrived");
   end

endmodule

`default_nettype wire

// ==== build.f ====
pcie_tx_pkg.sv
req_if.sv
fwft_fifo.sv
req_arbiter.sv
tlp_tx_formatter.sv
pcie_tx_top.sv
pcie_tx_asserts.sv
tb_pcie_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the PCIe tx bridge testbench with Verilator and runs it;
# the run passes only when the log holds the pass message
rm -f sim.log
verilator --binary --assert --top-module tb_pcie_tx -f build.f -o sim_pcie_tx > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_pcie_tx > sim.log 2>&1
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
